// File: common/word_store_consts.svh
// geometry of the wide-word store
// WS_WORDS and WS_PIECES must both be at least 2
// WS_PIECE_W is the native data width of the block RAM
`ifndef WORD_STORE_CONSTS_SVH
`define WORD_STORE_CONSTS_SVH

// number of wide words held by the store
`define WS_WORDS 16

// width of one ram word in bits
`define WS_PIECE_W 32

// ram words per wide word, piece 0 holds the lsbs
`define WS_PIECES 4

// ram depth is WS_WORDS * WS_PIECES, so 64 words by default
// word a, piece k sits at ram address a * WS_PIECES + k

`endif

// File: common/word_store_pkg.sv
// shared types for the wide-word store
// all widths follow the macros in the consts header
`include "word_store_consts.svh"

package word_store_pkg;

  // one block ram word
  typedef logic [`WS_PIECE_W-1:0] piece_t;

  // one wide value, WS_PIECES ram words side by side
  typedef logic [(`WS_PIECES * `WS_PIECE_W)-1:0] word_t;

  typedef logic [$clog2(`WS_WORDS)-1:0] word_addr_t;  // client side address
  typedef logic [$clog2(`WS_WORDS * `WS_PIECES)-1:0] ram_addr_t;  // ram side address

  // client request, strobes are single cycle
  typedef struct packed {
    word_addr_t addr;     // wide word index
    word_t      wr_data;  // value to store on a write
    logic       rd_stb;   // read request
    logic       wr_stb;   // write request, wins over rd_stb
  } client_req_t;

  // block ram port, we and regce are exclusive
  typedef struct packed {
    ram_addr_t addr;   // registered inside the ram
    logic      we;     // write din at addr on this edge
    logic      regce;  // load the output register
    piece_t    din;    // write data
  } ram_req_t;

  // sequencer state
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ
  } seq_state_t;

endpackage

// File: hw/word_store/piece_ram.sv
`timescale 1ns/10ps
// behavioral single-port block ram with the output register turned on
// read data shows up two edges after the address, regce gates the second stage
// contents are undefined after power up, there is no reset
`include "word_store_consts.svh"

module piece_ram
  import word_store_pkg::*;
(
  input  logic     clk_in,
  input  ram_req_t req,
  output piece_t   dout
);

  localparam int DEPTH = `WS_WORDS * `WS_PIECES;

  piece_t    mem [DEPTH];  // storage array
  ram_addr_t addr_q;       // address register, first read stage

  // write port uses the address presented on this edge
  always_ff @(posedge clk_in) begin
    if (req.we) begin
      mem[req.addr] <= req.din;
    end
  end

  // two stage read path
  always_ff @(posedge clk_in) begin
    addr_q <= req.addr;  // stage 1, loaded every edge
    if (req.regce) begin
      dout <= mem[addr_q];  // stage 2, only when enabled
    end
  end

  // a write must land inside the array
  a_wr_addr_range : assert property (
    @(posedge clk_in) req.we |-> (int'(req.addr) < DEPTH)
  ) else $error("piece_ram: write address %0d out of range", req.addr);

  // the output register must read from inside the array
  a_rd_addr_range : assert property (
    @(posedge clk_in) req.regce |-> (int'(addr_q) < DEPTH)
  ) else $error("piece_ram: read address %0d out of range", addr_q);

  // sequencer never mixes a write with an output register load
  a_we_regce_excl : assert property (
    @(posedge clk_in) req.we |-> !req.regce
  ) else $error("piece_ram: we and regce high together");

endmodule

// File: hw/word_store/piece_sequencer.sv
`timescale 1ns/10ps
// one request at a time, strobes seen while busy are dropped, write wins over read
// write done comes WS_PIECES+1 cycles after acceptance, read done WS_PIECES+2
// reads keep up to two pieces in flight behind the two stage ram
`include "word_store_consts.svh"

module piece_sequencer
  import word_store_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_in,
  input  client_req_t client,
  output word_t       rd_data,
  output logic        done,
  output logic        busy,
  output ram_req_t    ram,
  input  piece_t      ram_dout
);

  localparam int P      = `WS_PIECES;
  localparam int PW     = `WS_PIECE_W;
  localparam int WORD_W = $bits(word_t);
  localparam int CNT_W  = $clog2(P + 1);  // counts 0..P

  seq_state_t       state;
  ram_addr_t        addr_q;     // current piece address
  logic             we_q;
  logic [CNT_W-1:0] piece_cnt;  // write piece / read issue count
  logic [CNT_W-1:0] cap_cnt;    // read pieces captured so far
  logic             iss_v;      // address on the bus belongs to a read
  logic [1:0]       vld;        // read valid, one bit per ram stage
  word_t            word_q;     // latched write word
  piece_t           din_q;      // slice on the ram write data
  word_t            asm_q;      // read assembly, fills from the top
  word_t            asm_next;
  ram_addr_t        base_addr;
  logic             accept;

  assign accept    = (state == ST_IDLE) && (client.rd_stb || client.wr_stb);
  assign base_addr = ram_addr_t'(client.addr) * ram_addr_t'(P);  // piece 0 of the word
  assign asm_next  = {ram_dout, asm_q[WORD_W-1:PW]};  // new piece enters at the msb end
  assign busy      = (state != ST_IDLE);

  always_comb begin
    ram.addr  = addr_q;
    ram.we    = we_q;
    ram.regce = vld[0];  // address is in the ram address register now
    ram.din   = din_q;
  end

  // control path
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= ST_IDLE;
      addr_q    <= '0;
      we_q      <= 1'b0;
      piece_cnt <= '0;
      cap_cnt   <= '0;
      iss_v     <= 1'b0;
      vld       <= '0;
      done      <= 1'b0;
      rd_data   <= '0;
    end else begin
      done <= 1'b0;             // single cycle pulse
      vld  <= {vld[0], iss_v};  // follows the ram pipeline
      case (state)
        ST_IDLE: begin
          if (accept) begin
            addr_q <= base_addr;
            if (client.wr_stb) begin
              state     <= ST_WRITE;
              we_q      <= 1'b1;  // piece 0 goes out right away
              piece_cnt <= '0;
            end else begin
              state     <= ST_READ;
              iss_v     <= 1'b1;  // piece 0 address issued
              piece_cnt <= CNT_W'(1);
              cap_cnt   <= '0;
            end
          end
        end
        ST_WRITE: begin
          if (piece_cnt == CNT_W'(P)) begin
            done  <= 1'b1;  // one gap cycle after the last write
            state <= ST_IDLE;
          end else if (piece_cnt == CNT_W'(P - 1)) begin
            we_q      <= 1'b0;  // last piece written on this edge
            piece_cnt <= CNT_W'(P);
          end else begin
            addr_q    <= addr_q + 1'b1;
            piece_cnt <= piece_cnt + 1'b1;
          end
        end
        ST_READ: begin
          if (piece_cnt < CNT_W'(P)) begin
            addr_q    <= addr_q + 1'b1;  // one address per cycle
            piece_cnt <= piece_cnt + 1'b1;
          end else begin
            iss_v <= 1'b0;  // all addresses out
          end
          if (vld[1]) begin
            cap_cnt <= cap_cnt + 1'b1;
            if (cap_cnt == CNT_W'(P - 1)) begin
              rd_data <= asm_next;  // whole word at once
              done    <= 1'b1;
              state   <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // data path
  always_ff @(posedge clk_in) begin
    if (accept && client.wr_stb) begin
      word_q <= client.wr_data;
      din_q  <= client.wr_data[PW-1:0];
    end else if ((state == ST_WRITE) && (piece_cnt < CNT_W'(P - 1))) begin
      din_q <= word_q[(int'(piece_cnt) + 1) * PW +: PW];  // next slice up
    end
    if (vld[1]) begin
      asm_q <= asm_next;
    end
  end

  // busy only drops together with done
  a_busy_done : assert property (
    @(posedge clk_in) disable iff (rst_in) $fell(busy) |-> done
  ) else $error("piece_sequencer: busy fell without done");

  // done is a pulse
  a_done_pulse : assert property (
    @(posedge clk_in) disable iff (rst_in) done |=> !done
  ) else $error("piece_sequencer: done high two cycles");

  // a piece cannot come back before its address went out
  a_cap_le_issue : assert property (
    @(posedge clk_in) disable iff (rst_in) (state == ST_READ) |-> (cap_cnt <= piece_cnt)
  ) else $error("piece_sequencer: capture %0d ahead of issue %0d", cap_cnt, piece_cnt);

endmodule

// File: hw/word_store_top.sv
`timescale 1ns/10ps
// wide-word store, client port on one side, block ram inside
// the client must wait for busy to fall before the next strobe
// rd_data holds the last read word, writes leave it alone
`include "word_store_consts.svh"

module word_store_top
  import word_store_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_in,
  input  client_req_t client,   // address, write word and strobes
  output word_t       rd_data,  // last word read
  output logic        done,     // request finished
  output logic        busy      // request in progress
);

  ram_req_t ram_req;   // sequencer to ram
  piece_t   ram_dout;  // ram output register

  // splits and gathers wide words
  piece_sequencer i_seq (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .client   (client),
    .rd_data  (rd_data),
    .done     (done),
    .busy     (busy),
    .ram      (ram_req),
    .ram_dout (ram_dout)
  );

  // WS_WORDS * WS_PIECES pieces
  piece_ram i_ram (
    .clk_in (clk_in),
    .req    (ram_req),
    .dout   (ram_dout)
  );

endmodule

// File: sim/tb_word_store.sv
`timescale 1ns/10ps
// directed testbench for the wide-word store, expects a write done WS_PIECES+1
// and a read done WS_PIECES+2 cycles after acceptance
// inputs change on the rising edge, outputs are sampled on the falling edge
`include "word_store_consts.svh"

module tb_word_store
  import word_store_pkg::*;
();

  localparam int P           = `WS_PIECES;
  localparam int WORDS       = `WS_WORDS;
  localparam int WR_LAT      = P + 1;
  localparam int RD_LAT      = P + 2;
  localparam int RST_CYCLES  = 5;
  localparam int DONE_WAIT   = 4 * P + 8;       // give up on a done pulse after this
  localparam int IDLE_CYCLES = 16;              // idle cycles spent by the hold test
  localparam int N_REQ       = 13 + 2 * WORDS;  // requests over all tests
  localparam int TIMEOUT_CYCLES = 2 * (RST_CYCLES + N_REQ * (P + 4) + IDLE_CYCLES);

  logic        clk_in;
  logic        rst_in;
  client_req_t client;
  word_t       rd_data;
  logic        done;
  logic        busy;

  word_t       ref_mem [WORDS];  // expected store contents
  word_t       exp_rd;           // expected rd_data
  logic [15:0] lfsr_q;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt = 0;

  word_store_top i_dut (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .client  (client),
    .rd_data (rd_data),
    .done    (done),
    .busy    (busy)
  );

  initial clk_in = 1'b0;
  always #50 clk_in = ~clk_in;  // 100 ns period

  // hard stop for a hung DUT
  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic next_word(output word_t w);
    for (int i = 0; i < $bits(word_t); i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      w[i]   = lfsr_q[0];
    end
  endtask

  task automatic next_index(input int bound, output int idx);
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i]   = lfsr_q[0];
    end
    idx = int'(v) % bound;
  endtask

  function automatic client_req_t make_req(input int addr, input word_t data,
                                           input logic rd, input logic wr);
    client_req_t r;
    r.addr    = word_addr_t'(addr);
    r.wr_data = data;
    r.rd_stb  = rd;
    r.wr_stb  = wr;
    return r;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // returns right after the acceptance edge
  task automatic start_request(input client_req_t req);
    @(negedge clk_in);
    while (busy) @(negedge clk_in);
    @(posedge clk_in);
    client <= req;
    @(posedge clk_in);  // DUT accepts here
    client.rd_stb <= 1'b0;
    client.wr_stb <= 1'b0;
  endtask

  // one cycle write strobe while the DUT is busy
  task automatic poke_write(input client_req_t req);
    @(posedge clk_in);
    client <= req;
    @(posedge clk_in);
    client.rd_stb <= 1'b0;
    client.wr_stb <= 1'b0;
  endtask

  // done, busy and rd_data are checked on every cycle up to the done pulse
  task automatic finish_request(input int lat, input word_t rd_before, input word_t rd_after,
                                input string what);
    int   n;
    logic seen;
    n    = 0;  // rising edges since the acceptance edge
    seen = 1'b0;
    while (!seen && n < DONE_WAIT) begin
      @(negedge clk_in);
      seen = done;
      check_bit({what, " done"}, done, n == lat);
      check_bit({what, " busy"}, busy, n < lat);
      check_word({what, " rd_data"}, rd_data, (n >= lat) ? rd_after : rd_before);
      n++;
    end
    if (!seen) begin
      $display("%s: done never arrived within %0d cycles", what, DONE_WAIT);
      errors++;
    end
  endtask

  task automatic do_request(input client_req_t req, input bit poke_en,
                            input client_req_t poke, input string what);
    int    lat;
    word_t rd_after;
    lat      = req.wr_stb ? WR_LAT : RD_LAT;  // write wins
    rd_after = req.wr_stb ? exp_rd : ref_mem[req.addr];
    start_request(req);
    fork
      finish_request(lat, exp_rd, rd_after, what);
      begin
        if (poke_en) poke_write(poke);
      end
    join
    if (req.wr_stb) begin
      ref_mem[req.addr] = req.wr_data;
    end else begin
      exp_rd = rd_after;
    end
  endtask

  task automatic write_word(input int addr, input word_t data);
    do_request(make_req(addr, data, 1'b0, 1'b1), 1'b0, '0, $sformatf("write %0d", addr));
  endtask

  task automatic read_word(input int addr);
    do_request(make_req(addr, '0, 1'b1, 1'b0), 1'b0, '0, $sformatf("read %0d", addr));
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge clk_in);
      check_word("idle rd_data", rd_data, exp_rd);
      check_bit("idle busy", busy, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk_in);
    check_bit("reset done", done, 1'b0);
    check_bit("reset busy", busy, 1'b0);
    check_word("reset rd_data", rd_data, '0);
    exp_rd = '0;
    report_test("reset", e0);
  endtask

  task automatic test_round_trip();
    int    e0;
    word_t w;
    e0 = errors;
    next_word(w);
    write_word(0, w);
    read_word(0);
    next_word(w);
    write_word(WORDS - 1, w);
    read_word(WORDS - 1);
    check_word("round trip rd_data", rd_data, w);  // last word written
    report_test("round_trip", e0);
  endtask

  task automatic test_isolation();
    int    e0;
    int    order [WORDS];
    int    j;
    int    tmp;
    word_t w;
    e0 = errors;
    for (int a = 0; a < WORDS; a++) begin
      next_word(w);
      write_word(a, w);
      order[a] = a;
    end
    for (int i = WORDS - 1; i > 0; i--) begin  // shuffle the read order
      next_index(i + 1, j);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < WORDS; i++) begin
      read_word(order[i]);
    end
    report_test("isolation", e0);
  endtask

  task automatic test_ignored_busy();
    int    e0;
    word_t w_new;
    word_t w_poke;
    e0 = errors;
    next_word(w_new);
    next_word(w_poke);
    // stray write to WORDS-2 during a write to 1
    do_request(make_req(1, w_new, 1'b0, 1'b1), 1'b1,
               make_req(WORDS - 2, w_poke, 1'b0, 1'b1), "busy write");
    read_word(WORDS - 2);
    // and again during a read
    do_request(make_req(1, '0, 1'b1, 1'b0), 1'b1,
               make_req(WORDS - 2, w_poke, 1'b0, 1'b1), "busy read");
    read_word(WORDS - 2);
    report_test("ignored_busy", e0);
  endtask

  task automatic test_priority();
    int    e0;
    word_t w;
    e0 = errors;
    next_word(w);
    do_request(make_req(WORDS / 2, w, 1'b1, 1'b1), 1'b0, '0, "both strobes");
    read_word(WORDS / 2);
    check_word("priority rd_data", rd_data, w);
    report_test("priority", e0);
  endtask

  task automatic test_hold();
    int    e0;
    word_t w;
    e0 = errors;
    read_word(0);
    idle_check(IDLE_CYCLES / 2);
    next_word(w);
    write_word(1, w);  // rd_data must not move
    idle_check(IDLE_CYCLES / 2);
    read_word(WORDS - 1);
    report_test("hold", e0);
  endtask

  initial begin
    rst_in       <= 1'b1;
    client       <= '0;
    lfsr_q       = 16'd45035;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RST_CYCLES) @(posedge clk_in);
    rst_in <= 1'b0;
    test_reset();
    test_round_trip();
    test_isolation();
    test_ignored_busy();
    test_priority();
    test_hold();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+common
common/word_store_pkg.sv
hw/word_store/piece_ram.sv
hw/word_store/piece_sequencer.sv
hw/word_store_top.sv
sim/tb_word_store.sv

// File: run.sh
#!/bin/sh
# builds the wide-word store testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_word_store \
  -f project.f \
  -o sim_word_store

# a crashed or failed run simply lacks the pass line
out=$(./obj_dir/sim_word_store) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS'; then
  exit 0
else
  exit 1
fi
